/* spmm_params.svh */
// SpMM size definitions
`ifndef SPMM_PARAMS_SVH
`define SPMM_PARAMS_SVH

// ====================
// Matrix dimensions
// ====================
// Rows of H handled per pass
`define SPMM_NUM_ROWS        12
// Columns of H, rows of W
`define SPMM_NUM_IN          32
// Output features, one MAC lane each
`define SPMM_NUM_OUT         4

// Datapath widths
`define SPMM_VAL_WIDTH       8
// Lane sums wrap at this width
`define SPMM_ACC_WIDTH       20
`define SPMM_ROW_LEN_WIDTH   4
`define SPMM_NUM_NODE_WIDTH  8
`define SPMM_NNZ_ADDR_WIDTH  8

// Node-info queue entries
`define SPMM_NI_FIFO_DEPTH   4

`endif

/* spmm_pkg.sv */
// SpMM shared types
`default_nettype none

`include "spmm_params.svh"

package spmm_pkg;

  // Field types
  typedef logic [$clog2(`SPMM_NUM_IN)-1:0]    col_idx_t;
  typedef logic signed [`SPMM_VAL_WIDTH-1:0]  val_t;
  typedef logic [`SPMM_ROW_LEN_WIDTH-1:0]     row_len_t;
  typedef logic [`SPMM_NUM_NODE_WIDTH-1:0]    num_node_t;
  typedef logic signed [`SPMM_ACC_WIDTH-1:0]  acc_t;
  typedef logic [$clog2(`SPMM_NUM_ROWS)-1:0]  row_addr_t;

  // Node-info memory word
  typedef struct packed {
    row_len_t  row_len;
    num_node_t num_node;
    logic      src_flag;
  } node_info_t;

  // H-data memory word, one nonzero
  typedef struct packed {
    col_idx_t col_idx;
    val_t     val;
  } nz_t;

  // Lane 0 sits in the low bits
  typedef val_t [`SPMM_NUM_OUT-1:0] wgt_row_t;
  typedef acc_t [`SPMM_NUM_OUT-1:0] wh_row_t;

endpackage

`default_nettype wire

/* node_info_prefetcher.sv */
// Node-info prefetch queue
`timescale 1ns/1ns
`default_nettype none

`include "spmm_params.svh"

module node_info_prefetcher (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  start_i,
  input  wire spmm_pkg::node_info_t  ni_rdata_i,
  output spmm_pkg::row_addr_t        ni_addr_o,
  input  wire logic                  ni_pop_i,
  output logic                       ni_valid_o,
  output spmm_pkg::node_info_t       ni_head_o
);

  localparam int DEPTH = `SPMM_NI_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam spmm_pkg::row_addr_t LAST_ROW = spmm_pkg::row_addr_t'(`SPMM_NUM_ROWS - 1);

  spmm_pkg::node_info_t  queue_mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [PTR_W:0]        count_q;
  spmm_pkg::row_addr_t   rd_addr_q;
  logic                  rd_active_q;
  logic                  rd_pend_q;
  logic                  rd_issue;
  logic                  push;
  logic                  full;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (int'(ptr) == DEPTH - 1) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // ====================
  // Memory read side
  // ====================
  // Entries held plus the read in flight never exceed the depth
  assign rd_issue  = rd_active_q && ((int'(count_q) + int'(rd_pend_q)) < DEPTH);
  assign ni_addr_o = rd_addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr_q   <= '0;
      rd_active_q <= 1'b0;
      rd_pend_q   <= 1'b0;
    end else begin
      rd_pend_q <= rd_issue;
      if (start_i) begin
        rd_addr_q   <= '0;
        rd_active_q <= 1'b1;
      end else if (rd_issue) begin
        if (rd_addr_q == LAST_ROW) begin
          rd_active_q <= 1'b0;
        end else begin
          rd_addr_q <= rd_addr_q + 1'b1;
        end
      end
    end
  end

  // ====================
  // Circular queue
  // ====================
  // Data shows up one cycle after the read was issued
  assign push       = rd_pend_q;
  assign full       = (int'(count_q) == DEPTH);
  assign ni_valid_o = (count_q != '0);
  assign ni_head_o  = queue_mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (push) begin
      queue_mem[wr_ptr_q] <= ni_rdata_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (start_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (ni_pop_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push, ni_pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
    else $error("node-info queue written while full");
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) ni_pop_i |-> ni_valid_o)
    else $error("node-info queue popped while empty");

endmodule

`default_nettype wire

/* row_sequencer.sv */
// Row sequencing FSM
`timescale 1ns/1ns
`default_nettype none

`include "spmm_params.svh"

module row_sequencer (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic                        start_i,
  input  wire logic                        ni_valid_i,
  input  wire spmm_pkg::node_info_t        ni_head_i,
  output logic                             ni_pop_o,
  output logic [`SPMM_NNZ_ADDR_WIDTH-1:0]  nz_addr_o,
  output logic                             nz_vld_o,
  input  wire logic                        last_row_i,
  output logic                             row_we_o,
  output spmm_pkg::num_node_t              wh_num_node_o,
  output logic                             wh_src_flag_o,
  output logic                             busy_o,
  output logic                             done_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_WAIT,
    S_STREAM,
    S_DRAIN,
    S_WRITE
  } state_t;

  state_t                           state_q;
  state_t                           state_d;
  spmm_pkg::node_info_t             entry_q;
  spmm_pkg::row_len_t               nz_left_q;
  logic                             drain_q;
  logic [`SPMM_NNZ_ADDR_WIDTH-1:0]  nz_ptr_q;
  logic                             issue;
  logic                             done_q;

  assign ni_pop_o      = (state_q == S_WAIT) && ni_valid_i;
  assign issue         = (state_q == S_STREAM);
  assign row_we_o      = (state_q == S_WRITE);
  assign busy_o        = (state_q != S_IDLE);
  assign done_o        = done_q;
  assign nz_addr_o     = nz_ptr_q;
  assign wh_num_node_o = entry_q.num_node;
  assign wh_src_flag_o = entry_q.src_flag;

  // ====================
  // Next state
  // ====================
  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (start_i) begin
          state_d = S_WAIT;
        end
      end
      S_WAIT: begin
        // Empty rows skip straight to the write
        if (ni_valid_i) begin
          state_d = (ni_head_i.row_len == '0) ? S_WRITE : S_STREAM;
        end
      end
      S_STREAM: begin
        if (nz_left_q == spmm_pkg::row_len_t'(1)) begin
          state_d = S_DRAIN;
        end
      end
      S_DRAIN: begin
        // Two cycles for the H and weight reads to land
        if (drain_q) begin
          state_d = S_WRITE;
        end
      end
      S_WRITE: state_d = last_row_i ? S_IDLE : S_WAIT;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= S_IDLE;
      nz_left_q <= '0;
      drain_q   <= 1'b0;
      nz_ptr_q  <= '0;
      nz_vld_o  <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      state_q  <= state_d;
      drain_q  <= (state_q == S_DRAIN) && !drain_q;
      // High in the cycle the nonzero word comes back from H memory
      nz_vld_o <= issue;
      if (start_i && (state_q == S_IDLE)) begin
        nz_ptr_q <= '0;
        done_q   <= 1'b0;
      end
      if (issue) begin
        nz_ptr_q  <= nz_ptr_q + 1'b1;
        nz_left_q <= nz_left_q - 1'b1;
      end
      if (ni_pop_o) begin
        nz_left_q <= ni_head_i.row_len;
      end
      if (row_we_o && last_row_i) begin
        done_q <= 1'b1;
      end
    end
  end

  // Node count and flag of the row in progress
  always_ff @(posedge clk) begin
    if (ni_pop_o) begin
      entry_q <= ni_head_i;
    end
  end

  a_row_complete: assert property (@(posedge clk) disable iff (!rst_n)
    row_we_o |-> (nz_left_q == '0))
    else $error("row written before all its nonzeros were issued");

endmodule

`default_nettype wire

/* row_counter.sv */
// Result row address counter
`timescale 1ns/1ns
`default_nettype none

`include "spmm_params.svh"

module row_counter (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            start_i,
  input  wire logic            row_we_i,
  output spmm_pkg::row_addr_t  wh_addr_o,
  output logic                 last_row_o
);

  localparam spmm_pkg::row_addr_t LAST_ROW = spmm_pkg::row_addr_t'(`SPMM_NUM_ROWS - 1);

  spmm_pkg::row_addr_t  addr_q;
  logic                 pass_end_q;

  assign wh_addr_o  = addr_q;
  assign last_row_o = (addr_q == LAST_ROW);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q     <= '0;
      pass_end_q <= 1'b0;
    end else if (start_i) begin
      addr_q     <= '0;
      pass_end_q <= 1'b0;
    end else if (row_we_i) begin
      // Address holds on the final row, pass is marked finished
      if (last_row_o) begin
        pass_end_q <= 1'b1;
      end else begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
    row_we_i |-> !pass_end_q)
    else $error("row write after the final row of the pass");

endmodule

`default_nettype wire

/* mac_array.sv */
// Multiply-accumulate lanes
`timescale 1ns/1ns
`default_nettype none

`include "spmm_params.svh"

module mac_array (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                nz_vld_i,
  input  wire spmm_pkg::val_t      nz_val_i,
  input  wire spmm_pkg::wgt_row_t  wgt_rdata_i,
  input  wire logic                clear_i,
  output spmm_pkg::wh_row_t        wh_data_o
);

  localparam int NUM_OUT = `SPMM_NUM_OUT;
  localparam int VW      = `SPMM_VAL_WIDTH;
  localparam int AW      = `SPMM_ACC_WIDTH;

  logic            vld_d_q;
  spmm_pkg::val_t  val_d_q;

  // ====================
  // Value delay stage
  // ====================
  // Lines the value up with the weight row read one cycle later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_d_q <= 1'b0;
    end else begin
      vld_d_q <= nz_vld_i;
    end
  end

  always_ff @(posedge clk) begin
    val_d_q <= nz_val_i;
  end

  // ====================
  // Lanes
  // ====================
  for (genvar g = 0; g < NUM_OUT; g++) begin : g_lane
    logic signed [2*VW-1:0]  prod;
    spmm_pkg::acc_t          acc_q;

    assign prod = $signed(val_d_q) * $signed(wgt_rdata_i[g]);

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        acc_q <= '0;
      end else if (clear_i) begin
        acc_q <= '0;
      end else if (vld_d_q) begin
        // Sign-extended product, sum wraps at AW bits
        acc_q <= acc_q + {{(AW - 2 * VW){prod[2*VW-1]}}, prod};
      end
    end

    assign wh_data_o[g] = acc_q;
  end

  a_no_clear_on_vld: assert property (@(posedge clk) disable iff (!rst_n)
    !(vld_d_q && clear_i))
    else $error("lane cleared while a product was due");

endmodule

`default_nettype wire

/* spmm_top.sv */
// Sparse times dense multiplier top
`timescale 1ns/1ns
`default_nettype none

`include "spmm_params.svh"

module spmm_top (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic                        start_i,
  output spmm_pkg::row_addr_t              ni_addr_o,
  input  wire spmm_pkg::node_info_t        ni_rdata_i,
  output logic [`SPMM_NNZ_ADDR_WIDTH-1:0]  nz_addr_o,
  input  wire spmm_pkg::nz_t               nz_rdata_i,
  output spmm_pkg::col_idx_t               wgt_addr_o,
  input  wire spmm_pkg::wgt_row_t          wgt_rdata_i,
  output logic                             wh_we_o,
  output spmm_pkg::row_addr_t              wh_addr_o,
  output spmm_pkg::wh_row_t                wh_data_o,
  output spmm_pkg::num_node_t              wh_num_node_o,
  output logic                             wh_src_flag_o,
  output logic                             busy_o,
  output logic                             done_o
);

  logic                  start_go;
  logic                  ni_valid;
  spmm_pkg::node_info_t  ni_head;
  logic                  ni_pop;
  logic                  nz_vld;
  logic                  last_row;

  // Start pulses during a pass are dropped
  assign start_go   = start_i && !busy_o;
  // Weight row follows the column of the returned nonzero
  assign wgt_addr_o = nz_rdata_i.col_idx;

  node_info_prefetcher u_prefetcher (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (start_go),
    .ni_rdata_i (ni_rdata_i),
    .ni_addr_o  (ni_addr_o),
    .ni_pop_i   (ni_pop),
    .ni_valid_o (ni_valid),
    .ni_head_o  (ni_head)
  );

  row_sequencer u_sequencer (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (start_go),
    .ni_valid_i    (ni_valid),
    .ni_head_i     (ni_head),
    .ni_pop_o      (ni_pop),
    .nz_addr_o     (nz_addr_o),
    .nz_vld_o      (nz_vld),
    .last_row_i    (last_row),
    .row_we_o      (wh_we_o),
    .wh_num_node_o (wh_num_node_o),
    .wh_src_flag_o (wh_src_flag_o),
    .busy_o        (busy_o),
    .done_o        (done_o)
  );

  row_counter u_counter (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (start_go),
    .row_we_i   (wh_we_o),
    .wh_addr_o  (wh_addr_o),
    .last_row_o (last_row)
  );

  mac_array u_mac (
    .clk         (clk),
    .rst_n       (rst_n),
    .nz_vld_i    (nz_vld),
    .nz_val_i    (nz_rdata_i.val),
    .wgt_rdata_i (wgt_rdata_i),
    .clear_i     (wh_we_o),
    .wh_data_o   (wh_data_o)
  );

endmodule

`default_nettype wire

/* tb_spmm.sv */
// SpMM testbench
`timescale 1ns/1ns
`default_nettype none

`include "spmm_params.svh"

module tb_spmm;

  localparam int NUM_ROWS   = `SPMM_NUM_ROWS;
  localparam int NUM_OUT    = `SPMM_NUM_OUT;
  localparam int MAX_LEN    = (1 << `SPMM_ROW_LEN_WIDTH) - 1;
  localparam int PASS_CYC   = NUM_ROWS * (MAX_LEN + 4) + 20;
  localparam int TIMEOUT_NS = 2 * (2 * PASS_CYC * 10);
  localparam int NI_DEPTH   = 1 << $bits(spmm_pkg::row_addr_t);
  localparam int NZ_DEPTH   = 1 << `SPMM_NNZ_ADDR_WIDTH;
  localparam int W_DEPTH    = `SPMM_NUM_IN;
  localparam logic [31:0] SEED = 32'h2bbef16c;

  logic                             clk;
  logic                             rst_n;
  logic                             start_i;
  logic                             started = 1'b0;
  spmm_pkg::row_addr_t              ni_addr;
  spmm_pkg::node_info_t             ni_rdata = '0;
  logic [`SPMM_NNZ_ADDR_WIDTH-1:0]  nz_addr;
  spmm_pkg::nz_t                    nz_rdata = '0;
  spmm_pkg::col_idx_t               wgt_addr;
  spmm_pkg::wgt_row_t               wgt_rdata = '0;
  logic                             wh_we_o;
  spmm_pkg::row_addr_t              wh_addr_o;
  spmm_pkg::wh_row_t                wh_data_o;
  spmm_pkg::num_node_t              wh_num_node_o;
  logic                             wh_src_flag_o;
  logic                             busy_o;
  logic                             done_o;

  spmm_pkg::node_info_t             ni_mem  [NI_DEPTH];
  spmm_pkg::nz_t                    nz_mem  [NZ_DEPTH];
  spmm_pkg::wgt_row_t               w_mem   [W_DEPTH];
  spmm_pkg::wh_row_t                ref_mem [NUM_ROWS];
  spmm_pkg::row_addr_t              ni_addr_s = '0;
  logic [`SPMM_NNZ_ADDR_WIDTH-1:0]  nz_addr_s = '0;
  spmm_pkg::col_idx_t               wgt_addr_s = '0;
  int                               wr_cnt = 0;
  spmm_pkg::node_info_t             exp_info;
  spmm_pkg::wh_row_t                exp_data;

  spmm_top dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (start_i),
    .ni_addr_o     (ni_addr),
    .ni_rdata_i    (ni_rdata),
    .nz_addr_o     (nz_addr),
    .nz_rdata_i    (nz_rdata),
    .wgt_addr_o    (wgt_addr),
    .wgt_rdata_i   (wgt_rdata),
    .wh_we_o       (wh_we_o),
    .wh_addr_o     (wh_addr_o),
    .wh_data_o     (wh_data_o),
    .wh_num_node_o (wh_num_node_o),
    .wh_src_flag_o (wh_src_flag_o),
    .busy_o        (busy_o),
    .done_o        (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ====================
  // Memory models
  // ====================
  // Address taken at the rising edge, data shows up at the next falling edge
  always @(posedge clk) begin
    ni_addr_s  <= ni_addr;
    nz_addr_s  <= nz_addr;
    wgt_addr_s <= wgt_addr;
  end

  always @(negedge clk) begin
    ni_rdata  <= ni_mem[ni_addr_s];
    nz_rdata  <= nz_mem[nz_addr_s];
    wgt_rdata <= w_mem[wgt_addr_s];
  end

  task automatic fill_memories();
    logic [31:0] rnd;
    for (int a = 0; a < NZ_DEPTH; a++) begin
      rnd = $urandom;
      nz_mem[a] = rnd[$bits(spmm_pkg::nz_t)-1:0];
    end
    for (int a = 0; a < W_DEPTH; a++) begin
      for (int j = 0; j < NUM_OUT; j++) begin
        rnd = $urandom;
        w_mem[a][j] = rnd[`SPMM_VAL_WIDTH-1:0];
      end
    end
    for (int r = 0; r < NI_DEPTH; r++) begin
      rnd = $urandom;
      ni_mem[r].row_len  = spmm_pkg::row_len_t'($urandom_range(0, MAX_LEN));
      ni_mem[r].num_node = rnd[`SPMM_NUM_NODE_WIDTH-1:0];
      ni_mem[r].src_flag = rnd[31];
    end
    // Empty rows in the middle and at the end, one full-length row
    ni_mem[3].row_len          = '0;
    ni_mem[NUM_ROWS-1].row_len = '0;
    ni_mem[6].row_len          = spmm_pkg::row_len_t'(MAX_LEN);
  endtask

  // Wrapped signed sum per output column, nonzeros packed row after row
  task automatic build_reference();
    int            ptr;
    int            prod;
    spmm_pkg::nz_t nz;
    ptr = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      ref_mem[r] = '0;
      for (int k = 0; k < int'(ni_mem[r].row_len); k++) begin
        nz  = nz_mem[ptr];
        ptr = ptr + 1;
        for (int j = 0; j < NUM_OUT; j++) begin
          prod = int'($signed(nz.val)) * int'($signed(w_mem[nz.col_idx][j]));
          ref_mem[r][j] = ref_mem[r][j] + spmm_pkg::acc_t'(prod);
        end
      end
    end
  endtask

  // Rows written so far in this pass, start is ignored while busy
  always @(posedge clk) begin
    if (start_i && !busy_o) begin
      wr_cnt   <= 0;
      exp_info <= ni_mem[0];
      exp_data <= ref_mem[0];
    end else if (wh_we_o) begin
      wr_cnt <= wr_cnt + 1;
      if (wr_cnt + 1 < NUM_ROWS) begin
        exp_info <= ni_mem[wr_cnt+1];
        exp_data <= ref_mem[wr_cnt+1];
      end
    end
  end

  task automatic stop_on_error();
    $display("Something failed");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  // ====================
  // Checks
  // ====================
  a_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !started |-> (!wh_we_o && !busy_o && !done_o))
    else begin
      $display("ERR %0t we/busy/done expected 000 actual %0b%0b%0b", $time,
               $sampled(wh_we_o), $sampled(busy_o), $sampled(done_o));
      stop_on_error();
    end

  a_count: assert property (@(posedge clk) disable iff (!rst_n)
    wh_we_o |-> (wr_cnt < NUM_ROWS))
    else begin
      $display("ERR %0t wh_we_o expected at most %0d writes actual %0d", $time,
               NUM_ROWS, $sampled(wr_cnt) + 1);
      stop_on_error();
    end

  a_addr: assert property (@(posedge clk) disable iff (!rst_n)
    wh_we_o |-> (int'(wh_addr_o) == wr_cnt))
    else begin
      $display("ERR %0t wh_addr_o expected %0d actual %0d", $time,
               $sampled(wr_cnt), $sampled(wh_addr_o));
      stop_on_error();
    end

  a_num_node: assert property (@(posedge clk) disable iff (!rst_n)
    wh_we_o |-> (wh_num_node_o == exp_info.num_node))
    else begin
      $display("ERR %0t wh_num_node_o expected %0d actual %0d", $time,
               $sampled(exp_info.num_node), $sampled(wh_num_node_o));
      stop_on_error();
    end

  a_src_flag: assert property (@(posedge clk) disable iff (!rst_n)
    wh_we_o |-> (wh_src_flag_o == exp_info.src_flag))
    else begin
      $display("ERR %0t wh_src_flag_o expected %0b actual %0b", $time,
               $sampled(exp_info.src_flag), $sampled(wh_src_flag_o));
      stop_on_error();
    end

  for (genvar g = 0; g < NUM_OUT; g++) begin : g_lane_chk
    a_lane: assert property (@(posedge clk) disable iff (!rst_n)
      wh_we_o |-> (wh_data_o[g] == exp_data[g]))
      else begin
        $display("ERR %0t wh_data_o[%0d] expected %0d actual %0d", $time, g,
                 $sampled(exp_data[g]), $sampled(wh_data_o[g]));
        stop_on_error();
      end
  end

  // Last write of a pass ends it in the very next cycle
  a_done_rise: assert property (@(posedge clk) disable iff (!rst_n)
    (wh_we_o && wr_cnt == NUM_ROWS - 1) |=> (done_o && !busy_o))
    else begin
      $display("ERR %0t done_o/busy_o expected 1/0 actual %0b/%0b", $time,
               $sampled(done_o), $sampled(busy_o));
      stop_on_error();
    end

  // Done only rises once every row of the pass is written
  a_done_count: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(done_o) |-> (wr_cnt == NUM_ROWS))
    else begin
      $display("ERR %0t wh_we_o expected %0d writes actual %0d", $time,
               NUM_ROWS, $sampled(wr_cnt));
      stop_on_error();
    end

  a_done_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (done_o && !start_i) |=> done_o)
    else begin
      $display("ERR %0t done_o expected 1 actual %0b", $time, $sampled(done_o));
      stop_on_error();
    end

  // ====================
  // Stimulus
  // ====================
  task automatic run_pass(input bit mid_start);
    int gap;
    start_i = 1'b1;
    started = 1'b1;
    @(negedge clk);
    start_i = 1'b0;
    if (mid_start) begin
      // Extra start while rows are still being written
      while (wr_cnt < 4) @(negedge clk);
      gap = int'($urandom_range(0, 6));
      repeat (gap) @(negedge clk);
      start_i = 1'b1;
      @(negedge clk);
      start_i = 1'b0;
    end
    while (!done_o) @(negedge clk);
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n   = 1'b0;
    start_i = 1'b0;
    fill_memories();
    build_reference();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk);
    run_pass(1'b0);
    repeat (4) @(negedge clk);
    run_pass(1'b1);
    repeat (2) @(negedge clk);
    $display("Everything OK");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before both passes completed");
    stop_on_error();
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
spmm_pkg.sv
node_info_prefetcher.sv
row_sequencer.sv
row_counter.sv
mac_array.sv
spmm_top.sv
tb_spmm.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the SpMM testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project directory"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module tb_spmm \
  --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

exit 0
